//--- verilog/pio_mem_pkg.sv
// PIO bus widths, word and address types, address map constants and controller state encoding.
package pio_mem_pkg;

	localparam int PIO_NBITS = 32; // register bus data width.
	localparam int PIO_ADDR_NBITS = 16; // register bus byte address width.

	typedef logic [PIO_NBITS-1:0] pio_word_t; // one register bus data word.
	typedef logic [PIO_ADDR_NBITS-1:0] pio_addr_t; // one register bus byte address.

	// Address map of the subsystem.
	// bits 15..13 must be zero, bit 12 picks the memory and the dword index starts at bit 2.
	localparam int MEM_SEL_BIT = 12; // 0 selects coefficients, 1 selects status.
	localparam int MAP_HI_LSB = 13; // any set bit from here up marks an unmapped access.
	localparam int DW_LSB = 2; // byte address bits below this are ignored.

	// States of the bus controller FSM.
	typedef enum logic [2:0] {
		idle, // waiting for a PIO strobe.
		issue, // strobing the selected memory for one cycle.
		wait_ack, // waiting for the selected memory to raise mem_ack.
		respond, // returning data and error to the PIO master.
		drain // waiting for mem_ack to drop before the next request.
	} pio_op_e;

endpackage

//--- verilog/pio_mem_if.sv
// Interface carrying one memory's PIO request and response, with controller and memory modports.
interface pio_mem_if import pio_mem_pkg::*; ();

	pio_addr_t addr; // byte address, held by the controller until the next request.
	pio_word_t din; // write data, held together with the address.
	logic rd; // one-cycle read strobe.
	logic wr; // one-cycle write strobe.
	logic ms; // memory select, qualifies rd and wr.
	logic mem_ack; // level ack, lasts one divider period.
	pio_word_t mem_rdata; // read data, valid while mem_ack is high.

	// The bus controller issues requests and watches the ack.
	modport ctrl (
		output addr,
		output din,
		output rd,
		output wr,
		output ms,
		input mem_ack,
		input mem_rdata
	);

	// The memory block serves requests and answers with ack and data.
	modport mem (
		input addr,
		input din,
		input rd,
		input wr,
		input ms,
		output mem_ack,
		output mem_rdata
	);

endinterface

//--- verilog/ram_1r1w.sv
// Simple dual-port RAM with one synchronous write port and one registered read port.
module ram_1r1w #(
	parameter type word_t = logic [31:0],
	parameter int DEPTH_NBITS = 6
) (
	input logic clk,
	input logic wr,
	input logic [DEPTH_NBITS-1:0] raddr,
	input logic [DEPTH_NBITS-1:0] waddr,
	input word_t din,
	output word_t dout
);

	localparam int DEPTH = 2 ** DEPTH_NBITS; // number of words in the array.

	word_t mem [DEPTH]; // the storage array, maps onto a block RAM.

	// Write and read happen on the same edge.
	// A read of the address being written returns the old word.
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din; // write lands at this edge.
		end
		dout <= mem[raddr]; // dout follows raddr by one cycle.
	end

endmodule

//--- verilog/pio_clk_div.sv
// Free-running counter that raises a one-cycle clk_div strobe every DIV_RATIO cycles.
module pio_clk_div #(
	parameter int DIV_RATIO = 4
) (
	input logic clk,
	input logic reset,
	output logic clk_div
);

	localparam int CNT_NBITS = (DIV_RATIO > 1) ? $clog2(DIV_RATIO) : 1; // counter width.
	localparam logic [CNT_NBITS-1:0] CNT_LAST = CNT_NBITS'(DIV_RATIO - 1); // wrap value.

	logic [CNT_NBITS-1:0] cnt; // position inside the current divider period.

	// The strobe marks the slow register bus cadence that memory acks align to.
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0; // start a fresh period.
			clk_div <= 1'b0; // no strobe during reset.
		end else begin
			if (cnt == CNT_LAST) begin
				cnt <= '0; // wrap back to the first count.
				clk_div <= 1'b1; // one strobe per wrap.
			end else begin
				cnt <= cnt + 1'b1; // keep counting up.
				clk_div <= 1'b0; // strobe lasts a single cycle.
			end
		end
	end

endmodule

//--- verilog/pio_rw_mem.sv
// Table memory with an application port, a PIO port, collision saving and strobe-aligned PIO ack.
module pio_rw_mem import pio_mem_pkg::*; #(
	parameter int WIDTH = 20,
	parameter int DEPTH_NBITS = 6,
	parameter bit REG_WR_EN = 1'b1
) (
	input logic clk,
	input logic reset,
	input logic clk_div,
	pio_mem_if.mem pio,
	input logic app_mem_rd,
	input logic [DEPTH_NBITS-1:0] app_mem_raddr,
	input logic app_mem_wr,
	input logic [DEPTH_NBITS-1:0] app_mem_waddr,
	input logic [WIDTH-1:0] app_mem_wdata,
	output logic app_mem_ack,
	output logic [WIDTH-1:0] app_mem_rdata
);

	typedef logic [WIDTH-1:0] word_t; // one stored table word.

	logic app_rd_d1; // application read in its d1 stage, owns the read port.
	logic app_rd_d2; // application read waiting for the RAM output.
	logic app_wr_d1; // application write in its d1 stage, owns the write port.
	logic [DEPTH_NBITS-1:0] app_raddr_d1; // registered application read address.
	logic [DEPTH_NBITS-1:0] app_waddr_d1; // registered application write address.
	word_t app_wdata_d1; // registered application write data.

	logic pio_rd_req; // PIO read strobe from the controller.
	logic pio_wr_req; // PIO write strobe from the controller.
	logic rd_save; // PIO read that lost the read port and waits.
	logic wr_save; // PIO write that lost the write port and waits.
	logic pio_rd_go; // PIO read is served at the RAM this cycle.
	logic pio_wr_go; // PIO write is served at the RAM this cycle.
	logic pio_rd_go_d1; // RAM output holds the PIO read word this cycle.
	logic ack_pend; // internal PIO ack waiting for the next divider strobe.
	logic [DEPTH_NBITS-1:0] pio_idx; // dword index taken from the PIO byte address.

	logic ram_wr; // write enable at the RAM.
	logic [DEPTH_NBITS-1:0] ram_raddr; // read address at the RAM.
	logic [DEPTH_NBITS-1:0] ram_waddr; // write address at the RAM.
	word_t ram_wdata; // write data at the RAM.
	word_t ram_rdata; // registered RAM output.

	assign pio_idx = pio.addr[DW_LSB +: DEPTH_NBITS]; // byte bits 1..0 are dropped.
	assign pio_rd_req = pio.ms & pio.rd; // read request for this memory.
	assign pio_wr_req = pio.ms & pio.wr; // write request for this memory.

	// A PIO access goes through only in a cycle with no application access of its kind.
	assign pio_rd_go = ~app_rd_d1 & (pio_rd_req | rd_save);
	assign pio_wr_go = ~app_wr_d1 & (pio_wr_req | wr_save);

	// The application stages have priority at both RAM ports.
	assign ram_raddr = app_rd_d1 ? app_raddr_d1 : pio_idx;
	assign ram_waddr = app_wr_d1 ? app_waddr_d1 : pio_idx;
	assign ram_wdata = app_wr_d1 ? app_wdata_d1 : pio.din[WIDTH-1:0];
	assign ram_wr = app_wr_d1 | (REG_WR_EN & pio_wr_go); // read-only tables drop PIO writes.

	// Application address and data stage.
	always_ff @(posedge clk) begin
		app_raddr_d1 <= app_mem_raddr;
		app_waddr_d1 <= app_mem_waddr;
		app_wdata_d1 <= app_mem_wdata;
	end

	// Strobe pipeline, collision save flags and the PIO ack path.
	always_ff @(posedge clk) begin
		if (reset) begin
			app_rd_d1 <= 1'b0;
			app_rd_d2 <= 1'b0;
			app_wr_d1 <= 1'b0;
			app_mem_ack <= 1'b0;
			rd_save <= 1'b0;
			wr_save <= 1'b0;
			pio_rd_go_d1 <= 1'b0;
			ack_pend <= 1'b0;
			pio.mem_ack <= 1'b0;
		end else begin
			app_rd_d1 <= app_mem_rd;
			app_rd_d2 <= app_rd_d1;
			app_wr_d1 <= app_mem_wr;
			app_mem_ack <= app_rd_d2; // three cycles after the read strobe.
			if (app_rd_d1 & pio_rd_req) begin
				rd_save <= 1'b1; // hold the read until the port is free.
			end else if (pio_rd_go) begin
				rd_save <= 1'b0;
			end
			if (app_wr_d1 & pio_wr_req) begin
				wr_save <= 1'b1; // hold the write until the port is free.
			end else if (pio_wr_go) begin
				wr_save <= 1'b0;
			end
			pio_rd_go_d1 <= pio_rd_go;
			// writes ack when served, reads once the word is out of the RAM.
			if (pio_wr_go | pio_rd_go_d1) begin
				ack_pend <= 1'b1;
			end else if (clk_div) begin
				ack_pend <= 1'b0; // cleared by the strobe after it was copied.
			end
			if (clk_div) begin
				pio.mem_ack <= ack_pend; // ack moves only on the divider strobe.
			end
		end
	end

	// Read data registers.
	always_ff @(posedge clk) begin
		app_mem_rdata <= ram_rdata; // lines up with app_mem_ack.
		if (pio_rd_go_d1) begin
			pio.mem_rdata <= pio_word_t'(ram_rdata); // zero-extended to the bus width.
		end
	end

	ram_1r1w #(
		.word_t(word_t),
		.DEPTH_NBITS(DEPTH_NBITS)
	) i_ram (
		.clk(clk),
		.wr(ram_wr),
		.raddr(ram_raddr),
		.waddr(ram_waddr),
		.din(ram_wdata),
		.dout(ram_rdata)
	);

endmodule

//--- verilog/pio_bus_ctrl.sv
// PIO bus controller FSM that decodes requests to the two memories and returns ack, data and error.
module pio_bus_ctrl import pio_mem_pkg::*; (
	input logic clk,
	input logic reset,
	input logic pio_rd,
	input logic pio_wr,
	input pio_addr_t pio_addr,
	input pio_word_t pio_din,
	output logic pio_ack,
	output pio_word_t pio_rdata,
	output logic pio_err,
	output logic pio_busy,
	pio_mem_if.ctrl coef,
	pio_mem_if.ctrl stat
);

	pio_op_e state; // current FSM state.
	pio_op_e state_nxt; // next FSM state.

	pio_addr_t addr_q; // latched request address.
	pio_word_t din_q; // latched write data.
	pio_word_t data_q; // read data collected from the memory.
	logic rd_q; // request kind, 1 for read and 0 for write.
	logic sel_q; // selected memory, 0 for coefficients and 1 for status.
	logic err_q; // request hit an unmapped address.

	logic req; // a new PIO strobe is present.
	logic unmapped; // the new address lies outside the map.
	logic sel_ack; // mem_ack of the selected memory.

	assign req = pio_rd | pio_wr;
	assign unmapped = |pio_addr[PIO_ADDR_NBITS-1:MAP_HI_LSB];
	assign sel_ack = sel_q ? stat.mem_ack : coef.mem_ack;
	assign pio_busy = (state != idle); // strobes given while busy are ignored.

	// Both memories see the held address and data; only the selected one gets ms.
	assign coef.addr = addr_q;
	assign coef.din = din_q;
	assign coef.rd = (state == issue) & rd_q;
	assign coef.wr = (state == issue) & ~rd_q;
	assign coef.ms = (state == issue) & ~sel_q;
	assign stat.addr = addr_q;
	assign stat.din = din_q;
	assign stat.rd = (state == issue) & rd_q;
	assign stat.wr = (state == issue) & ~rd_q;
	assign stat.ms = (state == issue) & sel_q;

	always_comb begin
		state_nxt = state;
		unique case (state)
			idle: begin
				if (req) begin
					state_nxt = unmapped ? respond : issue; // unmapped goes straight to the answer.
				end
			end
			issue: state_nxt = wait_ack;
			wait_ack: begin
				if (sel_ack) begin
					state_nxt = respond;
				end
			end
			respond: state_nxt = drain;
			drain: begin
				if (err_q | ~sel_ack) begin
					state_nxt = idle; // no memory was touched after an error.
				end
			end
			default: state_nxt = idle;
		endcase
	end

	// Control state and the registered ack and error outputs.
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			rd_q <= 1'b0;
			sel_q <= 1'b0;
			err_q <= 1'b0;
			pio_ack <= 1'b0;
			pio_err <= 1'b0;
		end else begin
			state <= state_nxt;
			if ((state == idle) & req) begin
				rd_q <= pio_rd; // a read wins when both strobes arrive together.
				sel_q <= pio_addr[MEM_SEL_BIT];
				err_q <= unmapped;
			end
			pio_ack <= (state == respond); // one pulse per request.
			pio_err <= (state == respond) & err_q;
		end
	end

	// Request and response payload.
	always_ff @(posedge clk) begin
		if ((state == idle) & req) begin
			addr_q <= pio_addr;
			din_q <= pio_din;
			data_q <= '0; // writes and unmapped reads return zero.
		end
		if ((state == wait_ack) & sel_ack & rd_q) begin
			data_q <= sel_q ? stat.mem_rdata : coef.mem_rdata;
		end
		if (state == respond) begin
			pio_rdata <= data_q; // valid together with pio_ack.
		end
	end

endmodule

//--- verilog/pio_mem_subsys.sv
// Top level of the table memory pair with divider, PIO bus controller and two memory blocks.
module pio_mem_subsys import pio_mem_pkg::*; #(
	parameter int COEF_WIDTH = 20,
	parameter int COEF_DEPTH_NBITS = 6,
	parameter int STAT_WIDTH = 12,
	parameter int STAT_DEPTH_NBITS = 5,
	parameter int DIV_RATIO = 4
) (
	input logic clk,
	input logic reset,
	input logic pio_rd,
	input logic pio_wr,
	input pio_addr_t pio_addr,
	input pio_word_t pio_din,
	output logic pio_ack,
	output pio_word_t pio_rdata,
	output logic pio_err,
	output logic pio_busy,
	input logic coef_rd,
	input logic [COEF_DEPTH_NBITS-1:0] coef_raddr,
	input logic coef_wr,
	input logic [COEF_DEPTH_NBITS-1:0] coef_waddr,
	input logic [COEF_WIDTH-1:0] coef_wdata,
	output logic coef_ack,
	output logic [COEF_WIDTH-1:0] coef_rdata,
	input logic stat_rd,
	input logic [STAT_DEPTH_NBITS-1:0] stat_raddr,
	input logic stat_wr,
	input logic [STAT_DEPTH_NBITS-1:0] stat_waddr,
	input logic [STAT_WIDTH-1:0] stat_wdata,
	output logic stat_ack,
	output logic [STAT_WIDTH-1:0] stat_rdata
);

	logic clk_div; // register bus cadence strobe.

	pio_mem_if coef_if (); // PIO link to the coefficient memory.
	pio_mem_if stat_if (); // PIO link to the status memory.

	pio_clk_div #(
		.DIV_RATIO(DIV_RATIO)
	) i_clk_div (
		.clk(clk),
		.reset(reset),
		.clk_div(clk_div)
	);

	pio_bus_ctrl i_bus_ctrl (
		.clk(clk),
		.reset(reset),
		.pio_rd(pio_rd),
		.pio_wr(pio_wr),
		.pio_addr(pio_addr),
		.pio_din(pio_din),
		.pio_ack(pio_ack),
		.pio_rdata(pio_rdata),
		.pio_err(pio_err),
		.pio_busy(pio_busy),
		.coef(coef_if.ctrl),
		.stat(stat_if.ctrl)
	);

	// Coefficients are writable from the register bus.
	pio_rw_mem #(
		.WIDTH(COEF_WIDTH),
		.DEPTH_NBITS(COEF_DEPTH_NBITS),
		.REG_WR_EN(1'b1)
	) i_coef_mem (
		.clk(clk),
		.reset(reset),
		.clk_div(clk_div),
		.pio(coef_if.mem),
		.app_mem_rd(coef_rd),
		.app_mem_raddr(coef_raddr),
		.app_mem_wr(coef_wr),
		.app_mem_waddr(coef_waddr),
		.app_mem_wdata(coef_wdata),
		.app_mem_ack(coef_ack),
		.app_mem_rdata(coef_rdata)
	);

	// Status is filled by the application and only read over the register bus.
	pio_rw_mem #(
		.WIDTH(STAT_WIDTH),
		.DEPTH_NBITS(STAT_DEPTH_NBITS),
		.REG_WR_EN(1'b0)
	) i_stat_mem (
		.clk(clk),
		.reset(reset),
		.clk_div(clk_div),
		.pio(stat_if.mem),
		.app_mem_rd(stat_rd),
		.app_mem_raddr(stat_raddr),
		.app_mem_wr(stat_wr),
		.app_mem_waddr(stat_waddr),
		.app_mem_wdata(stat_wdata),
		.app_mem_ack(stat_ack),
		.app_mem_rdata(stat_rdata)
	);

endmodule

//--- tests/pio_mem_props.sv
// Bound assertions on the PIO ack pulse, error flag, application read latency and controller issue.
module pio_mem_props import pio_mem_pkg::*; (
	input logic clk,
	input logic reset,
	input logic pio_ack,
	input logic pio_err,
	input logic coef_rd,
	input logic coef_ack,
	input logic stat_rd,
	input logic stat_ack,
	input pio_op_e ctrl_state,
	input logic coef_mem_ack,
	input logic stat_mem_ack
);

	localparam int APP_RD_LATENCY = 3; // application read strobe to ack, in cycles.

	// The PIO master sees exactly one ack cycle per request.
	ack_one_cycle: assert property (@(posedge clk) disable iff (reset) pio_ack |=> !pio_ack)
		else $error("pio_ack stayed high for more than one cycle");

	// The error flag is only meaningful together with the ack.
	err_with_ack: assert property (@(posedge clk) disable iff (reset) pio_err |-> pio_ack)
		else $error("pio_err is high without pio_ack");

	// A new request goes out only after the memory acks of the previous one have dropped.
	issue_after_ack_low: assert property (@(posedge clk) disable iff (reset)
		(ctrl_state == issue) |-> (!coef_mem_ack && !stat_mem_ack))
		else $error("request issued while a memory ack was still high");

	coef_rd_to_ack: assert property (@(posedge clk) disable iff (reset)
		coef_rd |-> ##APP_RD_LATENCY coef_ack)
		else $error("coef_ack missing three cycles after coef_rd");

	coef_ack_from_rd: assert property (@(posedge clk) disable iff (reset)
		coef_ack |-> $past(coef_rd, APP_RD_LATENCY))
		else $error("coef_ack without a coef_rd three cycles before");

	stat_rd_to_ack: assert property (@(posedge clk) disable iff (reset)
		stat_rd |-> ##APP_RD_LATENCY stat_ack)
		else $error("stat_ack missing three cycles after stat_rd");

	stat_ack_from_rd: assert property (@(posedge clk) disable iff (reset)
		stat_ack |-> $past(stat_rd, APP_RD_LATENCY))
		else $error("stat_ack without a stat_rd three cycles before");

endmodule

//--- tests/tb_pio_mem_subsys.sv
// Testbench for the table memory pair with stimulus table, shadow model, ack monitor and watchdog.
module tb_pio_mem_subsys import pio_mem_pkg::*; ();

	localparam int COEF_WIDTH = 20; // same values as the DUT defaults.
	localparam int COEF_DEPTH_NBITS = 6;
	localparam int STAT_WIDTH = 12;
	localparam int STAT_DEPTH_NBITS = 5;
	localparam int DIV_RATIO = 4;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_ENTRIES = 64;
	localparam int OP_CYCLES = 4 * DIV_RATIO + 20; // cycle budget of one table entry.
	localparam int APP_RD_LATENCY = 3;
	localparam logic [31:0] RND_SEED = 32'hb9e0_2838;
	localparam pio_word_t COEF_MASK = (32'd1 << COEF_WIDTH) - 1; // stored bits of a coefficient.
	localparam pio_word_t STAT_MASK = (32'd1 << STAT_WIDTH) - 1; // stored bits of a status word.

	// Operation kinds of one table entry.
	typedef enum int {k_pio_wr, k_pio_rd, k_app_wr, k_app_rd, k_both_rd, k_both_wr} op_kind_e;

	logic clk = 1'b0;
	logic reset;
	logic pio_rd, pio_wr, pio_ack, pio_err, pio_busy;
	pio_addr_t pio_addr;
	pio_word_t pio_din, pio_rdata;
	logic coef_rd, coef_wr, coef_ack;
	logic [COEF_DEPTH_NBITS-1:0] coef_raddr, coef_waddr;
	logic [COEF_WIDTH-1:0] coef_wdata, coef_rdata;
	logic stat_rd, stat_wr, stat_ack;
	logic [STAT_DEPTH_NBITS-1:0] stat_raddr, stat_waddr;
	logic [STAT_WIDTH-1:0] stat_wdata, stat_rdata;

	op_kind_e t_kind [MAX_ENTRIES]; // what the entry does.
	pio_addr_t t_addr [MAX_ENTRIES]; // PIO byte address.
	pio_word_t t_data [MAX_ENTRIES]; // PIO write data.
	pio_word_t t_exp [MAX_ENTRIES]; // expected pio_rdata, zero-extended.
	logic t_err [MAX_ENTRIES]; // expected pio_err.
	pio_addr_t t_app_addr [MAX_ENTRIES]; // application address, bit 12 picks the memory.
	pio_word_t t_app_val [MAX_ENTRIES]; // application write data or expected read word.
	logic t_chain [MAX_ENTRIES]; // application read issued right after the previous one.
	int n_entries;

	pio_word_t coef_shadow [2**COEF_DEPTH_NBITS]; // model of the coefficient table.
	pio_word_t stat_shadow [2**STAT_DEPTH_NBITS]; // model of the status table.

	logic exp_mem_q [$]; // outstanding application reads, memory select.
	pio_word_t exp_val_q [$]; // expected words of those reads.
	int exp_cyc_q [$]; // cycle in which each read was driven.
	int exp_idx_q [$]; // table entry of each read.

	int cycle; // clock count for latency checks.
	int checks = 0;
	int errors = 0;

	always #10 clk = ~clk; // 20 time unit period.

	always @(posedge clk) cycle <= reset ? 0 : cycle + 1;

	pio_mem_subsys i_pio_mem_subsys (.*);

	bind pio_mem_subsys pio_mem_props i_props (
		.clk(clk),
		.reset(reset),
		.pio_ack(pio_ack),
		.pio_err(pio_err),
		.coef_rd(coef_rd),
		.coef_ack(coef_ack),
		.stat_rd(stat_rd),
		.stat_ack(stat_ack),
		.ctrl_state(i_bus_ctrl.state),
		.coef_mem_ack(coef_if.mem_ack),
		.stat_mem_ack(stat_if.mem_ack)
	);

	task automatic check_value(input string what, input int i, input pio_word_t got,
			input pio_word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %0t: entry %0d %s is %h, expected %h", $time, i, what, got, exp);
		end
	endtask

	function automatic pio_addr_t byte_addr(input bit mem, input int idx, input int ofs);
		return pio_addr_t'((int'(mem) << MEM_SEL_BIT) | (idx << DW_LSB) | ofs); // ofs is ignored.
	endfunction

	function automatic pio_word_t shadow_read(input pio_addr_t a);
		if (a[MEM_SEL_BIT]) begin
			return stat_shadow[a[DW_LSB +: STAT_DEPTH_NBITS]];
		end
		return coef_shadow[a[DW_LSB +: COEF_DEPTH_NBITS]];
	endfunction

	function automatic void shadow_write(input pio_addr_t a, input pio_word_t d);
		if (a[MEM_SEL_BIT]) begin
			stat_shadow[a[DW_LSB +: STAT_DEPTH_NBITS]] = d & STAT_MASK; // upper bits are lost.
		end else begin
			coef_shadow[a[DW_LSB +: COEF_DEPTH_NBITS]] = d & COEF_MASK;
		end
	endfunction

	// Adds one entry and works out its expected responses from the shadow tables.
	function automatic void add_entry(input op_kind_e k, input pio_addr_t a, input pio_word_t d,
			input pio_addr_t aa, input pio_word_t ad, input bit chain);
		bit bad;
		bit pio_side;
		bad = |a[PIO_ADDR_NBITS-1:MAP_HI_LSB]; // bits 15..13 set means unmapped.
		pio_side = (k != k_app_wr) && (k != k_app_rd);
		t_kind[n_entries] = k;
		t_addr[n_entries] = a;
		t_data[n_entries] = d;
		t_app_addr[n_entries] = aa;
		t_chain[n_entries] = chain;
		t_err[n_entries] = pio_side && bad;
		if (k == k_app_wr || k == k_both_wr) begin
			shadow_write(aa, ad); // a colliding PIO write is saved and lands later.
		end
		t_app_val[n_entries] = (k == k_app_rd || k == k_both_rd) ? shadow_read(aa) : ad;
		t_exp[n_entries] = ((k == k_pio_rd || k == k_both_rd) && !bad) ? shadow_read(a) : '0;
		if ((k == k_pio_wr || k == k_both_wr) && !bad && !a[MEM_SEL_BIT]) begin
			shadow_write(a, d); // the status table drops PIO writes.
		end
		n_entries++;
	endfunction

	task automatic build_table();
		int k;
		n_entries = 0;
		for (k = 0; k < 4; k++) begin
			add_entry(k_app_wr, '0, '0, byte_addr(0, k, 0), $urandom, 0); // fill both tables.
			add_entry(k_app_wr, '0, '0, byte_addr(1, k, 0), $urandom, 0);
		end
		for (k = 0; k < 4; k++) begin
			add_entry(k_app_rd, '0, '0, byte_addr(0, k, 0), '0, k != 0); // back-to-back reads.
		end
		for (k = 0; k < 4; k++) begin
			add_entry(k_app_rd, '0, '0, byte_addr(1, k, 0), '0, k != 0);
		end
		add_entry(k_pio_wr, byte_addr(0, 5, 0), $urandom | 32'hfff0_0000, '0, '0, 0);
		add_entry(k_pio_rd, byte_addr(0, 5, 3), '0, '0, '0, 0); // truncated to 20 bits.
		add_entry(k_pio_rd, byte_addr(0, 2, 1), '0, '0, '0, 0); // app data seen over PIO.
		add_entry(k_pio_rd, byte_addr(1, 1, 2), '0, '0, '0, 0);
		add_entry(k_pio_wr, byte_addr(0, 6, 0), $urandom, '0, '0, 0);
		add_entry(k_app_rd, '0, '0, byte_addr(0, 6, 0), '0, 0); // PIO data seen by the app.
		add_entry(k_pio_wr, byte_addr(1, 2, 0), $urandom, '0, '0, 0); // acked but dropped.
		add_entry(k_pio_rd, byte_addr(1, 2, 0), '0, '0, '0, 0);
		add_entry(k_app_rd, '0, '0, byte_addr(1, 2, 0), '0, 0);
		add_entry(k_both_rd, byte_addr(0, 5, 0), '0, byte_addr(0, 0, 0), '0, 0); // collisions.
		add_entry(k_both_rd, byte_addr(1, 3, 0), '0, byte_addr(1, 1, 0), '0, 0);
		add_entry(k_both_wr, byte_addr(0, 7, 0), $urandom, byte_addr(0, 8, 0), $urandom, 0);
		add_entry(k_pio_rd, byte_addr(0, 8, 0), '0, '0, '0, 0);
		add_entry(k_app_rd, '0, '0, byte_addr(0, 7, 0), '0, 0);
		add_entry(k_pio_rd, byte_addr(0, 7, 0), '0, '0, '0, 0);
		add_entry(k_both_wr, byte_addr(1, 3, 0), $urandom, byte_addr(1, 5, 0), $urandom, 0);
		add_entry(k_pio_rd, byte_addr(1, 3, 0), '0, '0, '0, 0);
		add_entry(k_pio_rd, byte_addr(1, 5, 0), '0, '0, '0, 0);
		add_entry(k_pio_wr, 16'h2004, $urandom, '0, '0, 0); // unmapped aliases of word 1.
		add_entry(k_pio_wr, 16'h9004, $urandom, '0, '0, 0);
		add_entry(k_pio_rd, 16'h4008, '0, '0, '0, 0);
		add_entry(k_pio_rd, 16'he00c, '0, '0, '0, 0);
		add_entry(k_pio_rd, byte_addr(0, 1, 0), '0, '0, '0, 0); // both tables unchanged.
		add_entry(k_pio_rd, byte_addr(1, 1, 0), '0, '0, '0, 0);
		for (k = 20; k < 24; k++) begin
			add_entry(k_pio_wr, byte_addr(0, k, 0), $urandom, '0, '0, 0);
		end
		for (k = 20; k < 24; k++) begin
			add_entry(k_app_rd, '0, '0, byte_addr(0, k, 0), '0, k != 20);
		end
	endtask

	task automatic drive_app(input pio_addr_t a, input pio_word_t d, input bit wr);
		if (a[MEM_SEL_BIT]) begin
			stat_rd = ~wr;
			stat_wr = wr;
			stat_raddr = a[DW_LSB +: STAT_DEPTH_NBITS];
			stat_waddr = a[DW_LSB +: STAT_DEPTH_NBITS];
			stat_wdata = d[STAT_WIDTH-1:0];
		end else begin
			coef_rd = ~wr;
			coef_wr = wr;
			coef_raddr = a[DW_LSB +: COEF_DEPTH_NBITS];
			coef_waddr = a[DW_LSB +: COEF_DEPTH_NBITS];
			coef_wdata = d[COEF_WIDTH-1:0];
		end
	endtask

	task automatic clear_strobes();
		pio_rd = 1'b0;
		pio_wr = 1'b0;
		coef_rd = 1'b0;
		coef_wr = 1'b0;
		stat_rd = 1'b0;
		stat_wr = 1'b0;
	endtask

	// Starts and ends on a falling edge, with all strobes low at the end.
	task automatic run_entry(input int i);
		op_kind_e k;
		bit pio_side;
		int c;
		k = t_kind[i];
		pio_side = (k != k_app_wr) && (k != k_app_rd);
		c = 0;
		if (pio_side) begin
			pio_addr = t_addr[i];
			pio_din = t_data[i];
			pio_rd = (k == k_pio_rd) || (k == k_both_rd);
			pio_wr = (k == k_pio_wr) || (k == k_both_wr);
		end
		if (k == k_app_rd || k == k_both_rd) begin
			drive_app(t_app_addr[i], '0, 1'b0);
			exp_mem_q.push_back(t_app_addr[i][MEM_SEL_BIT]); // the monitor checks the ack.
			exp_val_q.push_back(t_app_val[i]);
			exp_cyc_q.push_back(cycle);
			exp_idx_q.push_back(i);
		end else if (k == k_app_wr || k == k_both_wr) begin
			drive_app(t_app_addr[i], t_app_val[i], 1'b1);
		end
		do begin
			@(negedge clk);
			c++;
			clear_strobes(); // every strobe lasts one cycle.
			if (pio_side && c == 1) begin
				check_value("pio_busy after the strobe", i, pio_word_t'(pio_busy), 32'd1);
			end
		end while (pio_side && !pio_ack && c < OP_CYCLES);
		if (pio_side && pio_ack) begin
			check_value("pio_err", i, pio_word_t'(pio_err), pio_word_t'(t_err[i]));
			if (t_err[i] || k == k_pio_rd || k == k_both_rd) begin
				check_value("pio_rdata", i, pio_rdata, t_exp[i]);
			end
			if (t_err[i]) begin
				check_value("unmapped ack latency", i, pio_word_t'(c), 32'd2);
			end else begin
				check_value("ack after 3 or more cycles", i, pio_word_t'(c >= 3), 32'd1);
			end
		end else if (pio_side) begin
			errors++;
			$display("entry %0d: no pio_ack within %0d cycles", i, OP_CYCLES);
		end
		c = 0;
		while (pio_busy && c < OP_CYCLES) begin
			@(negedge clk); // the controller drains the memory ack.
			c++;
		end
		if (pio_busy) begin
			errors++;
			$display("entry %0d: pio_busy did not drop after the access", i);
		end
		if (!(i + 1 < n_entries && t_chain[i + 1])) begin
			c = 0;
			while (exp_val_q.size() != 0 && c < OP_CYCLES) begin
				@(negedge clk);
				c++;
			end
			if (exp_val_q.size() != 0) begin
				errors++;
				$display("entry %0d: application read ack did not arrive", i);
				exp_mem_q.delete();
				exp_val_q.delete();
				exp_cyc_q.delete();
				exp_idx_q.delete();
			end
		end
	endtask

	// Application acks come back in read order, three cycles after each strobe.
	always @(negedge clk) begin
		logic mem;
		int idx;
		int issued;
		if (!reset && (coef_ack || stat_ack)) begin
			if (exp_val_q.size() == 0) begin
				errors++;
				$display("application read ack at time %0t with no read outstanding", $time);
			end else begin
				mem = exp_mem_q.pop_front();
				idx = exp_idx_q.pop_front();
				issued = exp_cyc_q.pop_front();
				check_value("app ack of the addressed memory", idx,
					pio_word_t'(mem ? stat_ack : coef_ack), 32'd1);
				check_value("app read latency", idx, pio_word_t'(cycle - issued),
					pio_word_t'(APP_RD_LATENCY));
				check_value("app rdata", idx,
					mem ? pio_word_t'(stat_rdata) : pio_word_t'(coef_rdata), exp_val_q.pop_front());
			end
		end
	end

	task automatic watchdog(input int limit);
		repeat (limit) @(posedge clk);
		$display("the run timed out after %0d cycles before the table was finished", limit);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	initial begin
		int i;
		reset = 1'b1;
		pio_addr = '0;
		pio_din = '0;
		coef_raddr = '0;
		coef_waddr = '0;
		coef_wdata = '0;
		stat_raddr = '0;
		stat_waddr = '0;
		stat_wdata = '0;
		clear_strobes();
		void'($urandom(RND_SEED)); // the one seed of the run.
		build_table();
		fork
			watchdog(n_entries * OP_CYCLES + RESET_CYCLES);
		join_none
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (i = 0; i < n_entries; i++) begin
			run_entry(i);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- list.f
verilog/pio_mem_pkg.sv
verilog/pio_mem_if.sv
verilog/ram_1r1w.sv
verilog/pio_clk_div.sv
verilog/pio_rw_mem.sv
verilog/pio_bus_ctrl.sv
verilog/pio_mem_subsys.sv
tests/pio_mem_props.sv
tests/tb_pio_mem_subsys.sv

//--- Bender.yml
package:
  name: pio_mem_subsys

sources:
  - files:
      - verilog/pio_mem_pkg.sv
      - verilog/pio_mem_if.sv
      - verilog/ram_1r1w.sv
      - verilog/pio_clk_div.sv
      - verilog/pio_rw_mem.sv
      - verilog/pio_bus_ctrl.sv
      - verilog/pio_mem_subsys.sv
  - target: test
    files:
      - tests/pio_mem_props.sv
      - tests/tb_pio_mem_subsys.sv
